//--- logic/tile_remote_macros.svh
// ~~~~~~~~~~~~~~~~~~~~
// tile remote router sizes, port counts and address field positions
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TILE_REMOTE_MACROS_SVH
`define TILE_REMOTE_MACROS_SVH

// cores and request ports of one tile
`define NUM_CORES    4
`define NUM_RD_PORTS 2
`define NUM_WR_PORTS 2
// port 0 is the local port, then read ports, then write ports
`define NUM_PORTS    (1 + `NUM_RD_PORTS + `NUM_WR_PORTS)

`define ADDR_WIDTH   32
`define DATA_WIDTH   32

// address map below the group field
`define BYTE_OFFSET  2
`define BANK_BITS    4
`define TILE_BITS    2
`define GROUP_BITS   2
`define GROUP_LSB    (`BYTE_OFFSET + `BANK_BITS + `TILE_BITS)

`endif

//--- logic/tile_addr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// tile address map types
// ~~~~~~~~~~~~~~~~~~~~
`include "tile_remote_macros.svh"

package tile_addr_pkg;

  // pre-scramble target address as issued by a core
  // fields from lsb: byte offset, bank, tile, group, upper word bits
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // group index, compared against the tile's own group
  typedef logic [`GROUP_BITS-1:0] group_id_t;

endpackage

//--- logic/tile_req_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// request payload and routing types
// ~~~~~~~~~~~~~~~~~~~~
`include "tile_remote_macros.svh"

package tile_req_pkg;

  // single word of write data
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // index of the issuing core inside the tile
  typedef logic [$clog2(`NUM_CORES)-1:0] core_idx_t;

  // crossbar output port number
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_sel_t;

  // class of port a request is routed to
  typedef enum logic [1:0] {
    PORT_LOCAL,
    PORT_READ,
    PORT_WRITE
  } port_kind_e;

endpackage

//--- logic/tile_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// demuxed core requests, demux to crossbar
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

interface tile_req_if
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
();

  // one lane per core
  logic      [`NUM_CORES-1:0] valid;
  logic      [`NUM_CORES-1:0] wen;
  logic      [`NUM_CORES-1:0] amoen;
  addr_t     [`NUM_CORES-1:0] addr;
  data_t     [`NUM_CORES-1:0] data;
  // target port picked by the demux
  port_sel_t [`NUM_CORES-1:0] sel;
  // driven by the crossbar grant logic
  logic      [`NUM_CORES-1:0] ready;

  modport demux (
    output valid, wen, amoen, addr, data, sel,
    input  ready
  );

  modport xbar (
    input  valid, wen, amoen, addr, data, sel,
    output ready
  );

endinterface

//--- logic/tile_rw_demux.sv
// ~~~~~~~~~~~~~~~~~~~~
// read/write demux, picks the target port of every core request
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

module tile_rw_demux
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
(
  input  group_id_t                   group_id_i,
  input  logic   [`NUM_CORES-1:0]     core_req_valid_i,
  input  logic   [`NUM_CORES-1:0]     core_req_wen_i,
  input  logic   [`NUM_CORES-1:0]     core_req_amoen_i,
  input  addr_t  [`NUM_CORES-1:0]     core_req_addr_i,
  input  data_t  [`NUM_CORES-1:0]     core_req_wdata_i,
  output logic   [`NUM_CORES-1:0]     core_req_ready_o,
  tile_req_if.demux                   req_o
);

  group_id_t  tgt_group [`NUM_CORES];
  port_kind_e tgt_kind  [`NUM_CORES];

  // classify each request by group match and access kind
  always_comb begin
    for (int c = 0; c < `NUM_CORES; c++) begin
      tgt_group[c] = core_req_addr_i[c][`GROUP_LSB +: `GROUP_BITS];
      if (tgt_group[c] == group_id_i) begin
        tgt_kind[c] = PORT_LOCAL;
      end else if (core_req_wen_i[c] || core_req_amoen_i[c]) begin
        // atomics share the write ports with stores
        tgt_kind[c] = PORT_WRITE;
      end else begin
        tgt_kind[c] = PORT_READ;
      end
    end
  end

  // port 0 local, then the read ports, then the write ports
  always_comb begin
    for (int c = 0; c < `NUM_CORES; c++) begin
      case (tgt_kind[c])
        PORT_LOCAL: req_o.sel[c] = '0;
        PORT_READ:  req_o.sel[c] = port_sel_t'(1 + (c % `NUM_RD_PORTS));
        default:    req_o.sel[c] = port_sel_t'(1 + `NUM_RD_PORTS + (c % `NUM_WR_PORTS));
      endcase
    end
  end

  // payload goes through as issued
  assign req_o.valid = core_req_valid_i;
  assign req_o.wen   = core_req_wen_i;
  assign req_o.amoen = core_req_amoen_i;
  assign req_o.addr  = core_req_addr_i;
  assign req_o.data  = core_req_wdata_i;

  // grant from the crossbar back to the cores
  assign core_req_ready_o = req_o.ready;

endmodule

//--- logic/tile_req_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~
// request crossbar, round-robin per output port with one-entry
// output registers and combinational ready back to the cores
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

module tile_req_xbar
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  tile_req_if.xbar                      req_i,
  output logic      [`NUM_PORTS-1:0]    port_req_valid_o,
  output logic      [`NUM_PORTS-1:0]    port_req_wen_o,
  output logic      [`NUM_PORTS-1:0]    port_req_amoen_o,
  output addr_t     [`NUM_PORTS-1:0]    port_req_addr_o,
  output data_t     [`NUM_PORTS-1:0]    port_req_wdata_o,
  output core_idx_t [`NUM_PORTS-1:0]    port_req_core_o,
  input  logic      [`NUM_PORTS-1:0]    port_req_ready_i
);

  // grants of every port, one bit per core
  logic [`NUM_PORTS-1:0][`NUM_CORES-1:0] port_gnt;
  logic [`NUM_CORES-1:0]                 core_ready;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_port
    logic [`NUM_CORES-1:0] port_req;
    logic [`NUM_CORES-1:0] gnt;
    core_idx_t             rr_q;
    core_idx_t             win_idx;
    logic                  win_found;
    logic                  can_load;
    logic                  do_load;

    // output register
    logic                  valid_q;
    logic                  wen_q;
    logic                  amoen_q;
    addr_t                 addr_q;
    data_t                 data_q;
    core_idx_t             core_q;

    // cores asking for this port
    always_comb begin
      for (int c = 0; c < `NUM_CORES; c++) begin
        port_req[c] = req_i.valid[c] && (req_i.sel[c] == port_sel_t'(p));
      end
    end

    // first requester at or after the pointer wins
    always_comb begin
      win_found = 1'b0;
      win_idx   = rr_q;
      for (int i = 0; i < `NUM_CORES; i++) begin
        int c;
        c = (int'(rr_q) + i) % `NUM_CORES;
        if (!win_found && port_req[c]) begin
          win_found = 1'b1;
          win_idx   = core_idx_t'(c);
        end
      end
    end

    // register free now or emptied by the port this cycle
    assign can_load = !valid_q || port_req_ready_i[p];
    assign do_load  = win_found && can_load;

    // a full register that is not drained grants nobody
    always_comb begin
      for (int c = 0; c < `NUM_CORES; c++) begin
        gnt[c] = do_load && (win_idx == core_idx_t'(c));
      end
    end

    assign port_gnt[p] = gnt;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q <= 1'b0;
        wen_q   <= 1'b0;
        amoen_q <= 1'b0;
        addr_q  <= '0;
        data_q  <= '0;
        core_q  <= '0;
        rr_q    <= '0;
      end else begin
        if (do_load) begin
          valid_q <= 1'b1;
          wen_q   <= req_i.wen[win_idx];
          amoen_q <= req_i.amoen[win_idx];
          addr_q  <= req_i.addr[win_idx];
          data_q  <= req_i.data[win_idx];
          core_q  <= win_idx;
          // next search starts just past the winner
          rr_q    <= core_idx_t'((int'(win_idx) + 1) % `NUM_CORES);
        end else if (port_req_ready_i[p]) begin
          valid_q <= 1'b0;
        end
      end
    end

    assign port_req_valid_o[p] = valid_q;
    assign port_req_wen_o[p]   = wen_q;
    assign port_req_amoen_o[p] = amoen_q;
    assign port_req_addr_o[p]  = addr_q;
    assign port_req_wdata_o[p] = data_q;
    assign port_req_core_o[p]  = core_q;
  end

  // each core targets exactly one port, so OR-ing the grants is enough
  always_comb begin
    core_ready = '0;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      core_ready = core_ready | port_gnt[p];
    end
  end

  assign req_i.ready = core_ready;

endmodule

//--- logic/tile_remote_router.sv
// ~~~~~~~~~~~~~~~~~~~~
// tile remote request path, demux followed by request crossbar
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

module tile_remote_router
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  group_id_t                     group_id_i,

  // core side
  input  logic      [`NUM_CORES-1:0]    core_req_valid_i,
  input  logic      [`NUM_CORES-1:0]    core_req_wen_i,
  input  logic      [`NUM_CORES-1:0]    core_req_amoen_i,
  input  addr_t     [`NUM_CORES-1:0]    core_req_addr_i,
  input  data_t     [`NUM_CORES-1:0]    core_req_wdata_i,
  output logic      [`NUM_CORES-1:0]    core_req_ready_o,

  // port side, port 0 is local
  output logic      [`NUM_PORTS-1:0]    port_req_valid_o,
  output logic      [`NUM_PORTS-1:0]    port_req_wen_o,
  output logic      [`NUM_PORTS-1:0]    port_req_amoen_o,
  output addr_t     [`NUM_PORTS-1:0]    port_req_addr_o,
  output data_t     [`NUM_PORTS-1:0]    port_req_wdata_o,
  output core_idx_t [`NUM_PORTS-1:0]    port_req_core_o,
  input  logic      [`NUM_PORTS-1:0]    port_req_ready_i
);

  tile_req_if req_if0 ();

  tile_rw_demux demux0 (
    .group_id_i       (group_id_i),
    .core_req_valid_i (core_req_valid_i),
    .core_req_wen_i   (core_req_wen_i),
    .core_req_amoen_i (core_req_amoen_i),
    .core_req_addr_i  (core_req_addr_i),
    .core_req_wdata_i (core_req_wdata_i),
    .core_req_ready_o (core_req_ready_o),
    .req_o            (req_if0.demux)
  );

  // one cycle from core handshake to port valid
  tile_req_xbar xbar0 (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_i            (req_if0.xbar),
    .port_req_valid_o (port_req_valid_o),
    .port_req_wen_o   (port_req_wen_o),
    .port_req_amoen_o (port_req_amoen_o),
    .port_req_addr_o  (port_req_addr_o),
    .port_req_wdata_o (port_req_wdata_o),
    .port_req_core_o  (port_req_core_o),
    .port_req_ready_i (port_req_ready_i)
  );

endmodule

//--- testbench/tile_remote_router_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~
// handshake assertions on the tile remote router
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

module tile_remote_router_asserts
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
(
  input logic                          clk_i,
  input logic                          reset_i,
  input group_id_t                     group_id_i,
  input logic      [`NUM_CORES-1:0]    core_req_wen_i,
  input logic      [`NUM_CORES-1:0]    core_req_amoen_i,
  input addr_t     [`NUM_CORES-1:0]    core_req_addr_i,
  input logic      [`NUM_CORES-1:0]    core_req_ready_o,
  input logic      [`NUM_PORTS-1:0]    port_req_valid_o,
  input logic      [`NUM_PORTS-1:0]    port_req_wen_o,
  input logic      [`NUM_PORTS-1:0]    port_req_amoen_o,
  input addr_t     [`NUM_PORTS-1:0]    port_req_addr_o,
  input data_t     [`NUM_PORTS-1:0]    port_req_wdata_o,
  input core_idx_t [`NUM_PORTS-1:0]    port_req_core_o,
  input logic      [`NUM_PORTS-1:0]    port_req_ready_i
);

  int fail_cnt = 0;
  logic [`NUM_PORTS-1:0][`NUM_CORES-1:0] ready_map;

  // ready cores sorted by the port their request targets
  always_comb begin
    ready_map = '0;
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (core_req_addr_i[c][`GROUP_LSB +: `GROUP_BITS] == group_id_i) begin
        ready_map[0][c] = core_req_ready_o[c];
      end else if (core_req_wen_i[c] || core_req_amoen_i[c]) begin
        ready_map[1 + `NUM_RD_PORTS + c % `NUM_WR_PORTS][c] = core_req_ready_o[c];
      end else begin
        ready_map[1 + c % `NUM_RD_PORTS][c] = core_req_ready_o[c];
      end
    end
  end

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_port
    // a stalled port keeps its request
    hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
      port_req_valid_o[p] && !port_req_ready_i[p] |=>
        port_req_valid_o[p] && $stable(port_req_wen_o[p]) && $stable(port_req_amoen_o[p]) &&
        $stable(port_req_addr_o[p]) && $stable(port_req_wdata_o[p]) &&
        $stable(port_req_core_o[p]))
      else begin
        fail_cnt++;
        $error("port %0d changed its request while stalled", p);
      end

    one_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(ready_map[p]))
      else begin
        fail_cnt++;
        $error("port %0d granted more than one core", p);
      end
  end

  reset_a: assert property (@(posedge clk_i) reset_i |=> port_req_valid_o == '0)
    else begin
      fail_cnt++;
      $error("port valid seen while in reset");
    end

endmodule

//--- testbench/tile_remote_router_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// tile remote router testbench, trace driven cores and random port stalls
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "tile_remote_macros.svh"

module tile_remote_router_tb
  import tile_addr_pkg::*;
  import tile_req_pkg::*;
();

  // one request from the trace with its expected port column
  typedef struct packed {
    logic      wen;
    logic      amoen;
    addr_t     addr;
    data_t     data;
    core_idx_t core;
    port_sel_t port;
  } req_t;

  logic                        clk;
  logic                        reset;
  group_id_t                   group_id;
  logic      [`NUM_CORES-1:0]  core_valid;
  logic      [`NUM_CORES-1:0]  core_wen;
  logic      [`NUM_CORES-1:0]  core_amoen;
  addr_t     [`NUM_CORES-1:0]  core_addr;
  data_t     [`NUM_CORES-1:0]  core_wdata;
  logic      [`NUM_CORES-1:0]  core_ready;
  logic      [`NUM_PORTS-1:0]  port_valid;
  logic      [`NUM_PORTS-1:0]  port_wen;
  logic      [`NUM_PORTS-1:0]  port_amoen;
  addr_t     [`NUM_PORTS-1:0]  port_addr;
  data_t     [`NUM_PORTS-1:0]  port_wdata;
  core_idx_t [`NUM_PORTS-1:0]  port_core;
  logic      [`NUM_PORTS-1:0]  port_ready;

  req_t        pend_q [`NUM_CORES][$];
  req_t        exp_q  [`NUM_PORTS][$];
  logic [31:0] rng_state;
  int          errors;
  int          timeouts;
  int          total;

  tile_remote_router dut0 (
    .clk_i (clk), .reset_i (reset), .group_id_i (group_id),
    .core_req_valid_i (core_valid), .core_req_wen_i (core_wen),
    .core_req_amoen_i (core_amoen), .core_req_addr_i (core_addr),
    .core_req_wdata_i (core_wdata), .core_req_ready_o (core_ready),
    .port_req_valid_o (port_valid), .port_req_wen_o (port_wen),
    .port_req_amoen_o (port_amoen), .port_req_addr_o (port_addr),
    .port_req_wdata_o (port_wdata), .port_req_core_o (port_core),
    .port_req_ready_i (port_ready)
  );

  bind tile_remote_router tile_remote_router_asserts asserts0 (
    .clk_i (clk_i), .reset_i (reset_i), .group_id_i (group_id_i),
    .core_req_wen_i (core_req_wen_i), .core_req_amoen_i (core_req_amoen_i),
    .core_req_addr_i (core_req_addr_i), .core_req_ready_o (core_req_ready_o),
    .port_req_valid_o (port_req_valid_o), .port_req_wen_o (port_req_wen_o),
    .port_req_amoen_o (port_req_amoen_o), .port_req_addr_o (port_req_addr_o),
    .port_req_wdata_o (port_req_wdata_o), .port_req_core_o (port_req_core_o),
    .port_req_ready_i (port_req_ready_i)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // own group goes local and other groups split by access kind and core index
  function automatic port_sel_t expected_port(input req_t r, input group_id_t gid);
    port_kind_e kind;
    if (r.addr[`GROUP_LSB +: `GROUP_BITS] == gid) kind = PORT_LOCAL;
    else if (r.wen || r.amoen) kind = PORT_WRITE;
    else kind = PORT_READ;
    case (kind)
      PORT_LOCAL: return port_sel_t'(0);
      PORT_READ:  return port_sel_t'(1 + r.core % `NUM_RD_PORTS);
      default:    return port_sel_t'(1 + `NUM_RD_PORTS + r.core % `NUM_WR_PORTS);
    endcase
  endfunction

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    int          c;
    int          w;
    int          a;
    int          p;
    logic [31:0] ad;
    logic [31:0] da;
    string       line;
    req_t        r;
    fd = $fopen("testbench/tile_remote_router_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("the trace file testbench/tile_remote_router_trace.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %d %h %h %d", c, w, a, ad, da, p);
          if (n == 6 && c >= 0 && c < `NUM_CORES) begin
            r.core  = core_idx_t'(c);
            r.wen   = w[0];
            r.amoen = a[0];
            r.addr  = ad;
            r.data  = da;
            r.port  = port_sel_t'(p);
            compare_values("trace port against routing rule",
                           32'(expected_port(r, group_id)), 32'(p));
            pend_q[c].push_back(r);
            total++;
          end
        end
      end
      $fclose(fd);
    end
    if (total == 0) begin
      errors++;
      $display("no requests were read from the trace");
    end
  endtask

  task automatic drive_inputs();
    req_t r;
    // front of each core queue stays on the bus until accepted
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (pend_q[c].size() > 0) begin
        r             = pend_q[c][0];
        core_valid[c] = 1'b1;
        core_wen[c]   = r.wen;
        core_amoen[c] = r.amoen;
        core_addr[c]  = r.addr;
        core_wdata[c] = r.data;
      end else begin
        core_valid[c] = 1'b0;
      end
    end
    // ready high on roughly three cycles out of four
    for (int p = 0; p < `NUM_PORTS; p++) begin
      rng_state     = xorshift32(rng_state);
      port_ready[p] = rng_state[3] | rng_state[11];
    end
  endtask

  task automatic sample_handshakes();
    req_t r;
    // ports before cores since a core accepted now shows up one cycle later
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (port_valid[p] && exp_q[p].size() == 0) begin
        errors++;
        $display("unexpected output at %0t: port %0d is valid with no request owed", $time, p);
      end else if (!port_valid[p] && exp_q[p].size() > 0) begin
        // an accepted request must be on the port one cycle after its handshake
        errors++;
        $display("missing output at %0t: port %0d owes a request but is not valid",
                 $time, p);
      end else if (port_valid[p] && port_ready[p]) begin
        r = exp_q[p].pop_front();
        compare_values($sformatf("port %0d wen", p), 32'(port_wen[p]), 32'(r.wen));
        compare_values($sformatf("port %0d amoen", p), 32'(port_amoen[p]), 32'(r.amoen));
        compare_values($sformatf("port %0d addr", p), port_addr[p], r.addr);
        compare_values($sformatf("port %0d wdata", p), port_wdata[p], r.data);
        compare_values($sformatf("port %0d core", p), 32'(port_core[p]), 32'(r.core));
      end
    end
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (core_valid[c] && core_ready[c]) begin
        r = pend_q[c].pop_front();
        exp_q[r.port].push_back(r);
      end
    end
  endtask

  function automatic bit work_left();
    bit busy;
    busy = (port_valid != '0);
    for (int c = 0; c < `NUM_CORES; c++) busy = busy || (pend_q[c].size() > 0);
    for (int p = 0; p < `NUM_PORTS; p++) busy = busy || (exp_q[p].size() > 0);
    return busy;
  endfunction

  initial begin
    int cycles;
    int limit;
    clk        = 1'b0;
    reset      = 1'b1;
    group_id   = group_id_t'(1);
    core_valid = '0;
    core_wen   = '0;
    core_amoen = '0;
    core_addr  = '0;
    core_wdata = '0;
    port_ready = '0;
    rng_state  = 32'h42247c10;
    errors     = 0;
    timeouts   = 0;
    total      = 0;
    cycles     = 0;
    load_trace();
    limit = 40 * total + 200;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    drive_inputs();
    while (work_left() && cycles < limit) begin
      @(posedge clk);
      cycles++;
      sample_handshakes();
      @(negedge clk);
      drive_inputs();
    end
    if (work_left()) begin
      timeouts++;
      $display("timeout after %0d cycles with requests still in flight", cycles);
    end
    $display("errors %0d, assertion failures %0d, timeouts %0d",
             errors, dut0.asserts0.fail_cnt, timeouts);
    if (errors == 0 && timeouts == 0 && dut0.asserts0.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/tile_addr_pkg.sv
logic/tile_req_pkg.sv
logic/tile_req_if.sv
logic/tile_rw_demux.sv
logic/tile_req_xbar.sv
logic/tile_remote_router.sv
testbench/tile_remote_router_asserts.sv
testbench/tile_remote_router_tb.sv

//--- Makefile
# Verilator lint and simulation of the tile remote router

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tile_remote_router_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tile_remote_router_trace.txt
# columns: core wen amoen addr(hex) wdata(hex) expected_port
# group field is addr[9:8], the tile runs as group 1
0 0 0 00000104 00000000 0
1 1 0 00001108 a5a50001 0
2 0 1 0000210c 5a5a0002 0
3 1 0 00003110 12340003 0
0 0 0 00000014 00000000 1
1 0 0 00000218 00000000 2
2 0 0 0000031c 00000000 1
3 0 0 00004020 00000000 2
0 1 0 00000224 deadbeef 3
1 1 0 00000328 cafef00d 4
2 0 1 0000002c 0badc0de 3
3 1 1 00000230 feedface 4
0 1 0 00000140 11110000 0
1 1 0 00000144 22220001 0
2 1 0 00000148 33330002 0
3 1 0 0000014c 44440003 0
0 0 0 00000150 00000000 0
1 0 0 00000154 00000000 0
0 0 0 00000360 00000000 1
2 0 0 00000364 00000000 1
0 0 0 00000068 00000000 1
2 0 0 0000026c 00000000 1
1 1 0 00000070 77770001 4
3 0 1 00000374 88880003 4
1 0 1 00000278 99990001 4
3 1 0 0000007c aaaa0003 4
